// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////
	// datapath widths
	////////////////////////////////////////

	// instruction words and pc values
	typedef logic [31:0] data_word;

	// instruction fields
	typedef logic [5:0] opcode_field;
	typedef logic [4:0] reg_index;
	typedef logic [15:0] imm_field;

	////////////////////////////////////////
	// pc source select
	////////////////////////////////////////

	typedef logic [1:0] pc_sel;

	// sequential fetch, pc plus one
	localparam pc_sel PC_SEQ = 2'd0;
	// redirects from later stages
	localparam pc_sel PC_BRANCH = 2'd1;
	localparam pc_sel PC_JUMP = 2'd2;
	localparam pc_sel PC_REGISTER = 2'd3;

	////////////////////////////////////////
	// special words
	////////////////////////////////////////

	// all ones stops fetch
	localparam data_word HALT_WORD = 32'hffff_ffff;
	// bubble inserted on redirect
	localparam data_word NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

// File: logic/if_id_bus.sv
`timescale 1ns/1ps
`default_nettype none

// one fetched instruction on its way from fetch to decode
interface if_id_bus
	import fetch_pkg::*;
	();

	data_word pc_plus_one;
	data_word instruction;
	logic valid;
	logic halt;

	// producer side, fetch stage or the register output
	modport fetch (
		output pc_plus_one,
		output instruction,
		output valid,
		output halt
	);

	// register input side
	modport buffer (
		input pc_plus_one,
		input instruction,
		input valid,
		input halt
	);

	// decode stage reads everything
	modport decode (
		input pc_plus_one,
		input instruction,
		input valid,
		input halt
	);

endinterface

`default_nettype wire

// File: logic/instruction_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_mem
	import fetch_pkg::*;
#(
	parameter int ADDR_WIDTH = 11
) (
	input logic clk,
	input logic [ADDR_WIDTH-1:0] addr,
	input logic write_enable,
	input data_word write_data,
	output data_word read_data
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	// contents undefined until the host loads a program
	data_word mem [DEPTH];

	////////////////////////////////////////
	// write port
	////////////////////////////////////////

	// host writes land at the edge
	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[addr] <= write_data;
		end
	end

	////////////////////////////////////////
	// read port
	////////////////////////////////////////

	// asynchronous read, word at addr in the same cycle
	assign read_data = mem[addr];

endmodule

`default_nettype wire

// File: logic/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch
	import fetch_pkg::*;
#(
	parameter int ADDR_WIDTH = 11
) (
	input logic clk,
	input logic reset,
	input pc_sel pc_src,
	input data_word branch_address,
	input data_word jump_address,
	input data_word register_address,
	input logic stall,
	input logic debug,
	input logic [ADDR_WIDTH-1:0] debug_addr,
	input data_word debug_data,
	input logic debug_write,
	output data_word pc,
	output logic halted,
	if_id_bus.fetch fetch_out
);

	data_word pc_plus_one;
	data_word next_pc;
	data_word read_data;
	logic [ADDR_WIDTH-1:0] mem_addr;
	logic mem_write;
	logic halt_seen;
	logic frozen;

	////////////////////////////////////////
	// instruction memory
	////////////////////////////////////////

	// host owns the address while debug is high
	assign mem_addr = debug ? debug_addr : pc[ADDR_WIDTH-1:0];
	assign mem_write = debug & debug_write;

	instruction_mem #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_instruction_mem (
		.clk(clk),
		.addr(mem_addr),
		.write_enable(mem_write),
		.write_data(debug_data),
		.read_data(read_data)
	);

	////////////////////////////////////////
	// next pc
	////////////////////////////////////////

	assign pc_plus_one = pc + 32'd1;

	always_comb begin
		case (pc_src)
			PC_BRANCH: next_pc = branch_address;
			PC_JUMP: next_pc = jump_address;
			PC_REGISTER: next_pc = register_address;
			default: next_pc = pc_plus_one;
		endcase
	end

	// no pc update during stall, host access or after halt
	assign frozen = stall | debug | halted;
	assign halt_seen = (read_data == HALT_WORD);

	// pc stops on the halt word itself
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (!frozen) begin
			if (halt_seen) begin
				halted <= 1'b1;
			end else begin
				pc <= next_pc;
			end
		end
	end

	////////////////////////////////////////
	// bus towards the if/id register
	////////////////////////////////////////

	assign fetch_out.pc_plus_one = pc_plus_one;
	assign fetch_out.instruction = read_data;
	assign fetch_out.halt = halt_seen;
	assign fetch_out.valid = ~halted;

endmodule

`default_nettype wire

// File: logic/if_id_register.sv
`timescale 1ns/1ps
`default_nettype none

module if_id_register
	import fetch_pkg::*;
(
	input logic clk,
	input logic reset,
	input pc_sel pc_src,
	input logic stall,
	input logic debug,
	if_id_bus.buffer from_fetch,
	if_id_bus.fetch to_decode
);

	logic hold;
	logic flush;

	// stall and host access freeze the stage together with the pc
	assign hold = stall | debug;
	// any redirect discards the word fetched this cycle
	assign flush = (pc_src != PC_SEQ);

	////////////////////////////////////////
	// pipeline register
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			to_decode.pc_plus_one <= '0;
			to_decode.instruction <= NOP_WORD;
			to_decode.valid <= 1'b0;
			to_decode.halt <= 1'b0;
		end else if (!hold) begin
			if (flush) begin
				// bubble
				to_decode.pc_plus_one <= '0;
				to_decode.instruction <= NOP_WORD;
				to_decode.valid <= 1'b0;
				to_decode.halt <= 1'b0;
			end else begin
				to_decode.pc_plus_one <= from_fetch.pc_plus_one;
				to_decode.instruction <= from_fetch.instruction;
				to_decode.valid <= from_fetch.valid;
				to_decode.halt <= from_fetch.halt;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decode
	import fetch_pkg::*;
(
	if_id_bus.decode from_buffer,
	output logic id_valid,
	output logic id_halt,
	output data_word id_pc_plus_one,
	output opcode_field id_opcode,
	output reg_index id_rs,
	output reg_index id_rt,
	output reg_index id_rd,
	output data_word id_immediate,
	output data_word id_branch_target,
	output data_word id_jump_target
);

	data_word instr;
	imm_field imm;
	logic [25:0] jump_index;

	assign instr = from_buffer.instruction;

	////////////////////////////////////////
	// field extraction
	////////////////////////////////////////

	assign id_opcode = instr[31:26];
	assign id_rs = instr[25:21];
	assign id_rt = instr[20:16];
	assign id_rd = instr[15:11];
	assign imm = instr[15:0];
	assign jump_index = instr[25:0];

	// sign extend to a full word
	assign id_immediate = {{16{imm[15]}}, imm};

	////////////////////////////////////////
	// targets
	////////////////////////////////////////

	// relative to the word after the branch
	assign id_branch_target = from_buffer.pc_plus_one + id_immediate;

	// keep the upper region bits of pc plus one
	assign id_jump_target = {from_buffer.pc_plus_one[31:26], jump_index};

	////////////////////////////////////////
	// pass through
	////////////////////////////////////////

	assign id_pc_plus_one = from_buffer.pc_plus_one;
	assign id_valid = from_buffer.valid;
	assign id_halt = from_buffer.halt;

endmodule

`default_nettype wire

// File: logic/fetch_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_top
	import fetch_pkg::*;
#(
	parameter int ADDR_WIDTH = 11
) (
	input logic clk,
	input logic reset,
	// decisions from later stages
	input pc_sel pc_src,
	input data_word branch_address,
	input data_word jump_address,
	input data_word register_address,
	input logic stall,
	// host load port
	input logic debug,
	input logic [ADDR_WIDTH-1:0] debug_addr,
	input data_word debug_data,
	input logic debug_write,
	// fetch status
	output data_word pc,
	output logic halted,
	// decode fields
	output logic id_valid,
	output logic id_halt,
	output data_word id_pc_plus_one,
	output opcode_field id_opcode,
	output reg_index id_rs,
	output reg_index id_rt,
	output reg_index id_rd,
	output data_word id_immediate,
	output data_word id_branch_target,
	output data_word id_jump_target
);

	////////////////////////////////////////
	// stage buses
	////////////////////////////////////////

	if_id_bus fetch_bus ();
	if_id_bus decode_bus ();

	instruction_fetch #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.pc_src(pc_src),
		.branch_address(branch_address),
		.jump_address(jump_address),
		.register_address(register_address),
		.stall(stall),
		.debug(debug),
		.debug_addr(debug_addr),
		.debug_data(debug_data),
		.debug_write(debug_write),
		.pc(pc),
		.halted(halted),
		.fetch_out(fetch_bus.fetch)
	);

	if_id_register u_if_id (
		.clk(clk),
		.reset(reset),
		.pc_src(pc_src),
		.stall(stall),
		.debug(debug),
		.from_fetch(fetch_bus.buffer),
		.to_decode(decode_bus.fetch)
	);

	instruction_decode u_decode (
		.from_buffer(decode_bus.decode),
		.id_valid(id_valid),
		.id_halt(id_halt),
		.id_pc_plus_one(id_pc_plus_one),
		.id_opcode(id_opcode),
		.id_rs(id_rs),
		.id_rt(id_rt),
		.id_rd(id_rd),
		.id_immediate(id_immediate),
		.id_branch_target(id_branch_target),
		.id_jump_target(id_jump_target)
	);

endmodule

`default_nettype wire

// File: bench/fetch_decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_checker
	import fetch_pkg::*;
(
	input logic clk,
	input logic reset,
	input pc_sel pc_src,
	input logic stall,
	input logic debug,
	input data_word pc,
	input logic halted,
	input logic id_valid
);

	////////////////////////////////////////
	// reset, stall and halt
	////////////////////////////////////////

	// pipeline comes out of reset empty at address zero
	assert property (@(posedge clk) $fell(reset) |-> (pc == '0) && !id_valid)
		else $error("pc or id_valid wrong after reset");

	assert property (@(posedge clk) disable iff (reset) stall |=> $stable(pc))
		else $error("pc moved during stall");

	// halted is sticky until reset
	assert property (@(posedge clk) disable iff (reset) halted |=> halted)
		else $error("halted fell without reset");

	////////////////////////////////////////
	// redirect bubble
	////////////////////////////////////////

	assert property (@(posedge clk) disable iff (reset)
		(pc_src != PC_SEQ) && !stall && !debug |=> !id_valid)
		else $error("no bubble after redirect");

endmodule

bind fetch_decode_top fetch_decode_checker u_checker (.*);

`default_nettype wire

// File: bench/fetch_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_tb
	import fetch_pkg::*;
();

	localparam int ADDR_WIDTH = 11;
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic reset;
	pc_sel pc_src;
	data_word branch_address;
	data_word jump_address;
	data_word register_address;
	logic stall;
	logic debug;
	logic [ADDR_WIDTH-1:0] debug_addr;
	data_word debug_data;
	logic debug_write;
	data_word pc;
	logic halted;
	logic id_valid;
	logic id_halt;
	data_word id_pc_plus_one;
	opcode_field id_opcode;
	reg_index id_rs;
	reg_index id_rt;
	reg_index id_rd;
	data_word id_immediate;
	data_word id_branch_target;
	data_word id_jump_target;

	// mirror of every host write
	data_word model [1 << ADDR_WIDTH];
	int seed;

	fetch_decode_top #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) dut (
		.*
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s actual=%h expected=%h",
				$time, name, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	function automatic data_word random_word();
		data_word w;
		w = $urandom;
		if (w == HALT_WORD) begin
			w[31] = 1'b0;
		end
		return w;
	endfunction

	function automatic logic [159:0] id_outputs();
		return {9'd0, id_valid, id_halt, id_pc_plus_one, id_opcode, id_rs, id_rt, id_rd,
			id_immediate, id_branch_target, id_jump_target};
	endfunction

	// inputs set here take effect at the following edge
	task automatic drive(input pc_sel src, input data_word addr, input logic stl);
		@(posedge clk);
		pc_src <= src;
		branch_address <= (src == PC_BRANCH) ? addr : ~addr;
		jump_address <= (src == PC_JUMP) ? addr : ~addr;
		register_address <= (src == PC_REGISTER) ? addr : ~addr;
		stall <= stl;
		@(negedge clk);
	endtask

	task automatic write_word(input data_word addr, input data_word data);
		@(posedge clk);
		debug <= 1'b1;
		debug_write <= 1'b1;
		debug_addr <= addr[ADDR_WIDTH-1:0];
		debug_data <= data;
		model[addr[ADDR_WIDTH-1:0]] = data;
		@(negedge clk);
	endtask

	task automatic end_debug();
		@(posedge clk);
		debug <= 1'b0;
		debug_write <= 1'b0;
		@(negedge clk);
	endtask

	// decode of the word fetched from addr
	task automatic check_decode(input data_word addr);
		data_word w;
		data_word p1;
		data_word imm;
		w = model[addr[ADDR_WIDTH-1:0]];
		p1 = addr + 1;
		// two's complement value of the 16-bit offset
		imm = {16'h0000, w[15:0]};
		if (w[15]) begin
			imm = imm - 32'h0001_0000;
		end
		check("id_valid", 32'(id_valid), 1);
		check("id_halt", 32'(id_halt), 0);
		check("id_pc_plus_one", id_pc_plus_one, p1);
		check("id_opcode", 32'(id_opcode), 32'(w[31:26]));
		check("id_rs", 32'(id_rs), 32'(w[25:21]));
		check("id_rt", 32'(id_rt), 32'(w[20:16]));
		check("id_rd", 32'(id_rd), 32'(w[15:11]));
		check("id_immediate", id_immediate, imm);
		check("id_branch_target", id_branch_target, p1 + imm);
		check("id_jump_target", id_jump_target,
			(p1 & 32'hfc00_0000) | (w & 32'h03ff_ffff));
	endtask

	// one sequential edge, then next inputs
	task automatic seq_cycle(input pc_sel src, input data_word addr, input logic stl);
		data_word prev;
		prev = pc;
		drive(src, addr, stl);
		check("pc", pc, prev + 1);
		check_decode(prev);
	endtask

	task automatic redirect_edge(input data_word target);
		drive(PC_SEQ, 0, 1'b0);
		check("pc", pc, target);
		check("id_valid", 32'(id_valid), 0);
		check("id_instruction", {id_opcode, id_rs, id_rt, id_immediate[15:0]}, 0);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic load_and_run();
		for (int i = 0; i < 64; i++)
			write_word(i, random_word());
		end_debug();
		for (int i = 0; i < 60; i++)
			seq_cycle(PC_SEQ, 0, 1'b0);
	endtask

	task automatic stall_hold();
		int n;
		data_word held_pc;
		logic [159:0] held_id;
		logic [159:0] now;
		n = $urandom_range(1, 5);
		seq_cycle(PC_SEQ, 0, 1'b1);
		held_pc = pc;
		held_id = id_outputs();
		for (int k = 0; k < n; k++) begin
			drive(PC_SEQ, 0, k < n - 1);
			now = id_outputs();
			check("pc", pc, held_pc);
			for (int j = 0; j < 5; j++)
				check("id outputs", now[j*32 +: 32], held_id[j*32 +: 32]);
		end
		seq_cycle(PC_SEQ, 0, 1'b0);
	endtask

	task automatic redirects();
		data_word target;
		for (int s = 1; s < 4; s++) begin
			target = $urandom_range(0, 50);
			seq_cycle(pc_sel'(s), target, 1'b0);
			redirect_edge(target);
			seq_cycle(PC_SEQ, 0, 1'b0);
		end
	endtask

	// high pc bits reach the jump target
	task automatic field_decode();
		data_word base;
		data_word w;
		base = 32'hfc00_0000 | 32'd1000;
		// two spare words cover the fetches around the next host load
		for (int i = 0; i < 18; i++) begin
			w = random_word();
			w[15] = i[0];
			if (w == HALT_WORD) begin
				w[31] = 1'b0;
			end
			write_word(base + i, w);
		end
		end_debug();
		seq_cycle(PC_JUMP, base, 1'b0);
		redirect_edge(base);
		for (int i = 0; i < 16; i++)
			seq_cycle(PC_SEQ, 0, 1'b0);
	endtask

	task automatic halt_and_reset();
		for (int i = 0; i < 4; i++)
			write_word(1500 + i, random_word());
		write_word(1504, HALT_WORD);
		end_debug();
		seq_cycle(PC_JUMP, 1500, 1'b0);
		redirect_edge(1500);
		repeat (4) seq_cycle(PC_SEQ, 0, 1'b0);
		for (int i = 0; i < 11; i++) begin
			drive(PC_SEQ, 0, 1'b0);
			check("halted", 32'(halted), 1);
			check("pc", pc, 1504);
			check("id_halt", 32'(id_halt), 1);
		end
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		check("halted", 32'(halted), 0);
		check("pc", pc, 0);
		@(posedge clk);
		reset <= 1'b0;
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		pc_src = PC_SEQ;
		branch_address = '0;
		jump_address = '0;
		register_address = '0;
		stall = 1'b0;
		// fetch frozen until the program is loaded
		debug = 1'b1;
		debug_addr = '0;
		debug_data = '0;
		debug_write = 1'b0;
		seed = $urandom(32'h8cd0);
		@(posedge clk);
		reset <= 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check("pc", pc, 0);
		check("id_valid", 32'(id_valid), 0);
		load_and_run();
		stall_hold();
		redirects();
		field_decode();
		halt_and_reset();
		$display("RESULT: PASS");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: verilog.f
logic/fetch_pkg.sv
logic/if_id_bus.sv
logic/instruction_mem.sv
logic/instruction_fetch.sv
logic/if_id_register.sv
logic/instruction_decode.sv
logic/fetch_decode_top.sv
bench/fetch_decode_checker.sv
bench/fetch_decode_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module fetch_decode_tb \
	-o fetch_decode_sim &&
./obj_dir/fetch_decode_sim || exit 1
